//--- verilog/fetch_pkg.sv
package fetch_pkg;

  // pc, AXI address and AXI data width
  parameter int XLEN = 64;

  // one uncompressed instruction
  parameter int ILEN = 32;

  // addi x0,x0,0, shown whenever no valid instruction is offered
  parameter logic [ILEN-1:0] NOP_INST = 32'h0000_0013;

  // two-bit AXI response code
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  // read master: idle, address phase, data phase
  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,
    RD_DATA
  } rd_state_e;

  // instruction memory: accept, latency wait, response
  typedef enum logic [1:0] {
    MEM_IDLE,
    MEM_WAIT,
    MEM_RESP
  } mem_state_e;

endpackage

//--- verilog/pc_gen.sv
`timescale 1ns/1ps

module pc_gen import fetch_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000
) (
  input  logic            clk,
  input  logic            rst_n,
  // one pulse per instruction handed to decode
  input  logic            advance_i,
  // decode redirect, single cycle
  input  logic            redirect_i,
  input  logic [XLEN-1:0] redirect_pc_i,
  // address of the next fetch
  output logic [XLEN-1:0] pc_o
);

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_d;
  logic [XLEN-1:0] pc_seq;

  // sequential successor, no compressed instructions
  assign pc_seq = pc_q + XLEN'(4);

  // next pc select
  // redirect wins over advance, otherwise hold
  always_comb begin
    pc_d = pc_q;
    if (redirect_i) begin
      pc_d = redirect_pc_i;
    end else if (advance_i) begin
      pc_d = pc_seq;
    end
  end

  // pc register
  // comes out of reset pointing at the first fetch address
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= pc_d;
    end
  end

  // fetch stage samples this when it launches a read
  assign pc_o = pc_q;

endmodule

//--- verilog/axil_read_master.sv
`timescale 1ns/1ps

module axil_read_master import fetch_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  // request side, from the fetch stage
  input  logic            req_valid_i,
  input  logic [XLEN-1:0] req_addr_i,
  output logic            req_ready_o,
  // response side, one pulse per read
  output logic            rsp_valid_o,
  output logic [XLEN-1:0] rsp_data_o,
  output axi_resp_e       rsp_resp_o,
  // AR channel
  output logic            axi_arvalid_o,
  output logic [XLEN-1:0] axi_araddr_o,
  input  logic            axi_arready_i,
  // R channel
  input  logic            axi_rvalid_i,
  input  logic [XLEN-1:0] axi_rdata_i,
  input  axi_resp_e       axi_rresp_i,
  output logic            axi_rready_o
);

  rd_state_e       state_q;
  rd_state_e       state_d;
  logic [XLEN-1:0] addr_q;
  logic [XLEN-1:0] data_q;
  axi_resp_e       resp_q;
  logic            rsp_valid_q;
  logic            req_fire;
  logic            r_fire;

  assign req_fire = req_valid_i && (state_q == RD_IDLE);
  assign r_fire   = axi_rvalid_i && (state_q == RD_DATA);

  // one read at a time
  // idle -> address phase -> data phase -> idle
  always_comb begin
    state_d = state_q;
    case (state_q)
      RD_IDLE: if (req_valid_i) state_d = RD_ADDR;
      RD_ADDR: if (axi_arready_i) state_d = RD_DATA;
      RD_DATA: if (axi_rvalid_i) state_d = RD_IDLE;
      default: state_d = RD_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= RD_IDLE;
      rsp_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      // done pulse one cycle after the R handshake
      rsp_valid_q <= r_fire;
    end
  end

  // address held from request until AR handshake
  always_ff @(posedge clk) begin
    if (req_fire) begin
      addr_q <= req_addr_i;
    end
  end

  // read data and status kept for the fetch stage
  always_ff @(posedge clk) begin
    if (r_fire) begin
      data_q <= axi_rdata_i;
      resp_q <= axi_rresp_i;
    end
  end

  // accept new requests only when nothing is outstanding
  assign req_ready_o   = (state_q == RD_IDLE);
  // arvalid straight from state, so it cannot drop before arready
  assign axi_arvalid_o = (state_q == RD_ADDR);
  assign axi_araddr_o  = addr_q;
  assign axi_rready_o  = (state_q == RD_DATA);

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_data_o  = data_q;
  assign rsp_resp_o  = resp_q;

endmodule

//--- verilog/axil_imem.sv
`timescale 1ns/1ps

module axil_imem import fetch_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC    = 64'h0000_0000_8000_0000,
  parameter int              MEM_WORDS   = 16,
  parameter int              MEM_LATENCY = 2
) (
  input  logic            clk,
  input  logic            rst_n,
  // AR channel
  input  logic            axi_arvalid_i,
  input  logic [XLEN-1:0] axi_araddr_i,
  output logic            axi_arready_o,
  // R channel
  output logic            axi_rvalid_o,
  output logic [XLEN-1:0] axi_rdata_o,
  output axi_resp_e       axi_rresp_o,
  input  logic            axi_rready_i
);

  // index and latency counter widths, at least one bit each
  localparam int AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam int CW = (MEM_LATENCY > 0) ? $clog2(MEM_LATENCY + 1) : 1;

  logic [ILEN-1:0] mem [MEM_WORDS];

  mem_state_e      state_q;
  logic [CW-1:0]   cnt_q;
  logic [XLEN-1:0] rdata_q;
  axi_resp_e       rresp_q;
  logic [XLEN-1:0] offset;
  logic [XLEN-1:0] lo_idx;
  logic [XLEN-1:0] hi_idx;
  logic            in_range;
  logic            ar_fire;

  initial begin
    $readmemh("test/prog.hex", mem);
  end

  // word pair holding the address, 64-bit aligned
  assign offset   = axi_araddr_i - RESET_PC;
  assign lo_idx   = {offset[XLEN-1:3], 1'b0};
  assign hi_idx   = lo_idx + XLEN'(1);
  // below base or past the last word gets an error
  assign in_range = (axi_araddr_i >= RESET_PC) && (lo_idx < XLEN'(MEM_WORDS));
  assign ar_fire  = axi_arvalid_i && (state_q == MEM_IDLE);

  // latency FSM
  // cnt counts down the wait cycles after the AR handshake
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MEM_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        MEM_IDLE: begin
          if (axi_arvalid_i) begin
            cnt_q   <= CW'(MEM_LATENCY);
            state_q <= (MEM_LATENCY == 0) ? MEM_RESP : MEM_WAIT;
          end
        end
        MEM_WAIT: begin
          cnt_q <= cnt_q - CW'(1);
          if (cnt_q == CW'(1)) state_q <= MEM_RESP;
        end
        MEM_RESP: if (axi_rready_i) state_q <= MEM_IDLE;
        default:  state_q <= MEM_IDLE;
      endcase
    end
  end

  // read data captured at accept, held until rready
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      if (in_range) begin
        rdata_q[ILEN-1:0] <= mem[lo_idx[AW-1:0]];
        // odd depth leaves the top half empty
        rdata_q[XLEN-1:ILEN] <= (hi_idx < XLEN'(MEM_WORDS)) ? mem[hi_idx[AW-1:0]] : '0;
        rresp_q <= RESP_OKAY;
      end else begin
        rdata_q <= '0;
        rresp_q <= RESP_SLVERR;
      end
    end
  end

  assign axi_arready_o = (state_q == MEM_IDLE);
  assign axi_rvalid_o  = (state_q == MEM_RESP);
  assign axi_rdata_o   = rdata_q;
  assign axi_rresp_o   = rresp_q;

endmodule

//--- verilog/if_stage.sv
`timescale 1ns/1ps

module if_stage import fetch_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            stall_i,
  input  logic            redirect_i,
  input  logic [XLEN-1:0] pc_i,
  output logic            advance_o,
  // request/done side of the read master
  output logic            req_valid_o,
  output logic [XLEN-1:0] req_addr_o,
  input  logic            req_ready_i,
  input  logic            rsp_valid_i,
  input  logic [XLEN-1:0] rsp_data_i,
  input  axi_resp_e       rsp_resp_i,
  // instruction slot towards decode
  output logic [ILEN-1:0] inst_o,
  output logic [XLEN-1:0] inst_pc_o,
  output logic            inst_valid_o,
  output logic            inst_fault_o
);

  logic            busy_q;
  logic            kill_q;
  logic            slot_q;
  logic            fault_q;
  logic [XLEN-1:0] req_pc_q;
  logic [XLEN-1:0] inst_pc_q;
  logic [ILEN-1:0] inst_q;
  logic [ILEN-1:0] rsp_half;
  logic            launch;
  logic            take;
  logic            rsp_keep;

  // launch only with nothing in flight and the slot empty
  assign req_valid_o = !busy_q && !slot_q && !redirect_i;
  assign req_addr_o  = pc_i;
  assign launch      = req_valid_o && req_ready_i;
  // decode takes the slot when valid and not stalled
  assign take        = slot_q && !stall_i;
  assign advance_o   = take;
  // killed or redirected responses are dropped
  assign rsp_keep    = rsp_valid_i && busy_q && !kill_q && !redirect_i;
  // pc bit 2 picks the half of the 64-bit beat
  assign rsp_half    = req_pc_q[2] ? rsp_data_i[2*ILEN-1:ILEN] : rsp_data_i[ILEN-1:0];

  // in-flight tracking, kill set by a redirect mid-read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      kill_q <= 1'b0;
    end else if (launch) begin
      busy_q <= 1'b1;
      kill_q <= 1'b0;
    end else if (rsp_valid_i) begin
      busy_q <= 1'b0;
      kill_q <= 1'b0;
    end else if (redirect_i && busy_q) begin
      kill_q <= 1'b1;
    end
  end

  // pc of the read in flight
  always_ff @(posedge clk) begin
    if (launch) begin
      req_pc_q <= pc_i;
    end
  end

  // output slot
  // redirect beats stall, a fault shows up as a nop
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_q    <= 1'b0;
      fault_q   <= 1'b0;
      inst_q    <= NOP_INST;
      inst_pc_q <= '0;
    end else if (redirect_i || take) begin
      slot_q  <= 1'b0;
      fault_q <= 1'b0;
      inst_q  <= NOP_INST;
    end else if (rsp_keep) begin
      slot_q    <= 1'b1;
      fault_q   <= (rsp_resp_i != RESP_OKAY);
      inst_q    <= (rsp_resp_i == RESP_OKAY) ? rsp_half : NOP_INST;
      inst_pc_q <= req_pc_q;
    end
  end

  assign inst_o       = inst_q;
  assign inst_pc_o    = inst_pc_q;
  assign inst_valid_o = slot_q;
  assign inst_fault_o = fault_q;

endmodule

//--- verilog/fetch_top.sv
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC    = 64'h0000_0000_8000_0000,
  parameter int              MEM_WORDS   = 16,
  parameter int              MEM_LATENCY = 2
) (
  input  logic            clk,
  input  logic            rst_n,
  // back-pressure and redirect from decode
  input  logic            stall_i,
  input  logic            redirect_i,
  input  logic [XLEN-1:0] redirect_pc_i,
  // instruction handed to decode
  output logic [ILEN-1:0] inst_o,
  output logic [XLEN-1:0] inst_pc_o,
  output logic            inst_valid_o,
  output logic            inst_fault_o
);

  // pc_gen <-> if_stage
  logic [XLEN-1:0] pc;
  logic            advance;

  // if_stage <-> read master
  logic            req_valid;
  logic [XLEN-1:0] req_addr;
  logic            req_ready;
  logic            rsp_valid;
  logic [XLEN-1:0] rsp_data;
  axi_resp_e       rsp_resp;

  // AXI4-Lite read channels
  logic            arvalid;
  logic [XLEN-1:0] araddr;
  logic            arready;
  logic            rvalid;
  logic [XLEN-1:0] rdata;
  axi_resp_e       rresp;
  logic            rready;

  pc_gen #(
    .RESET_PC (RESET_PC)
  ) pc_gen_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .advance_i     (advance),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .pc_o          (pc)
  );

  if_stage if_stage_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .stall_i      (stall_i),
    .redirect_i   (redirect_i),
    .pc_i         (pc),
    .advance_o    (advance),
    .req_valid_o  (req_valid),
    .req_addr_o   (req_addr),
    .req_ready_i  (req_ready),
    .rsp_valid_i  (rsp_valid),
    .rsp_data_i   (rsp_data),
    .rsp_resp_i   (rsp_resp),
    .inst_o       (inst_o),
    .inst_pc_o    (inst_pc_o),
    .inst_valid_o (inst_valid_o),
    .inst_fault_o (inst_fault_o)
  );

  axil_read_master axil_read_master_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid_i   (req_valid),
    .req_addr_i    (req_addr),
    .req_ready_o   (req_ready),
    .rsp_valid_o   (rsp_valid),
    .rsp_data_o    (rsp_data),
    .rsp_resp_o    (rsp_resp),
    .axi_arvalid_o (arvalid),
    .axi_araddr_o  (araddr),
    .axi_arready_i (arready),
    .axi_rvalid_i  (rvalid),
    .axi_rdata_i   (rdata),
    .axi_rresp_i   (rresp),
    .axi_rready_o  (rready)
  );

  // memory based at the reset pc
  axil_imem #(
    .RESET_PC    (RESET_PC),
    .MEM_WORDS   (MEM_WORDS),
    .MEM_LATENCY (MEM_LATENCY)
  ) axil_imem_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .axi_arvalid_i (arvalid),
    .axi_araddr_i  (araddr),
    .axi_arready_o (arready),
    .axi_rvalid_o  (rvalid),
    .axi_rdata_o   (rdata),
    .axi_rresp_o   (rresp),
    .axi_rready_i  (rready)
  );

endmodule

//--- test/fetch_chk.sv
`timescale 1ns/1ps

module fetch_chk import fetch_pkg::*; (
  input logic            clk,
  input logic            rst_n,
  input logic            arvalid_i,
  input logic            arready_i,
  input logic [XLEN-1:0] araddr_i,
  input logic            rvalid_i,
  input logic            rready_i,
  input logic            stall_i,
  input logic            redirect_i,
  input logic            inst_valid_i,
  input logic [ILEN-1:0] inst_i,
  input logic [XLEN-1:0] inst_pc_i
);

  // AR held until the memory takes it
  ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    arvalid_i && !arready_i |=> arvalid_i)
    else $error("arvalid dropped before arready");

  ar_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    arvalid_i && !arready_i |=> $stable(araddr_i))
    else $error("araddr changed while arvalid waited");

  // R held until the master takes it
  r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid_i && !rready_i |=> rvalid_i)
    else $error("rvalid dropped before rready");

  // stalled slot frozen, a redirect may still flush it
  slot_stable: assert property (@(posedge clk) disable iff (!rst_n)
    inst_valid_i && stall_i && !redirect_i |=> $stable(inst_i) && $stable(inst_pc_i))
    else $error("instruction output changed under stall");

  // empty slot shows the nop
  nop_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !inst_valid_i |-> inst_i == NOP_INST)
    else $error("inst_o not nop while inst_valid_o low");

endmodule

bind fetch_top fetch_chk fetch_chk_i (
  .clk          (clk),
  .rst_n        (rst_n),
  .arvalid_i    (arvalid),
  .arready_i    (arready),
  .araddr_i     (araddr),
  .rvalid_i     (rvalid),
  .rready_i     (rready),
  .stall_i      (stall_i),
  .redirect_i   (redirect_i),
  .inst_valid_i (inst_valid_o),
  .inst_i       (inst_o),
  .inst_pc_i    (inst_pc_o)
);

//--- test/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

  // same values as the DUT parameters
  localparam logic [63:0] RESET_PC    = 64'h0000_0000_8000_0000;
  localparam int          MEM_WORDS   = 16;
  localparam int          MEM_LATENCY = 2;
  // addi x0,x0,0
  localparam logic [31:0] NOP_WORD    = 32'h0000_0013;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        stall_i;
  logic        redirect_i;
  logic [63:0] redirect_pc_i;
  logic [31:0] inst_o;
  logic [63:0] inst_pc_o;
  logic        inst_valid_o;
  logic        inst_fault_o;

  // model image and expected pc
  logic [31:0] prog [MEM_WORDS];
  logic [63:0] exp_pc = RESET_PC;
  int          acc_cnt = 0;
  int          fault_cnt = 0;
  int          err_cnt = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  integer      seed;

  fetch_top #(
    .RESET_PC    (RESET_PC),
    .MEM_WORDS   (MEM_WORDS),
    .MEM_LATENCY (MEM_LATENCY)
  ) fetch_top_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall_i       (stall_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .inst_o        (inst_o),
    .inst_pc_o     (inst_pc_o),
    .inst_valid_o  (inst_valid_o),
    .inst_fault_o  (inst_fault_o)
  );

  always #50 clk = ~clk;

  // expected word for a pc, plus fault flag and successor
  function automatic logic [31:0] ref_inst(input logic [63:0] pc, output logic fault,
                                           output logic [63:0] next_pc);
    logic [63:0] idx;
    next_pc = pc + 64'd4;
    if (pc < RESET_PC || pc >= RESET_PC + 64'(MEM_WORDS * 4)) begin
      fault = 1'b1;
      return NOP_WORD;
    end
    idx   = (pc - RESET_PC) >> 2;
    fault = 1'b0;
    return prog[int'(idx)];
  endfunction

  task automatic check_value(input string sig, input logic [63:0] exp, input logic [63:0] got);
    assert (got === exp) else begin
      $display("[ERROR] %0d ns: %s expected %h, got %h", $time, sig, exp, got);
      err_cnt++;
    end
  endtask

  // comparison process
  // negedge sample, inputs and outputs both settled
  always @(negedge clk) begin
    logic [31:0] exp_inst;
    logic        exp_fault;
    logic [63:0] nxt_pc;
    if (rst_n) begin
      if (inst_valid_o && !stall_i) begin
        exp_inst = ref_inst(exp_pc, exp_fault, nxt_pc);
        check_value("inst_pc_o", exp_pc, inst_pc_o);
        check_value("inst_o", 64'(exp_inst), 64'(inst_o));
        check_value("inst_fault_o", 64'(exp_fault), 64'(inst_fault_o));
        exp_pc = nxt_pc;
        acc_cnt++;
        // faults as seen on the DUT output
        if (inst_fault_o) fault_cnt++;
      end
      // redirect restarts the expected sequence
      if (redirect_i) exp_pc = redirect_pc_i;
    end
  end

  // inputs change 1 ns after the edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic pulse_redirect(input logic [63:0] target);
    redirect_i    = 1'b1;
    redirect_pc_i = target;
    step();
    redirect_i    = 1'b0;
  endtask

  // run until n more instructions accepted, stall optionally random
  task automatic wait_accepts(input int n, input bit rand_stall, input string what);
    int          target;
    int          cycles;
    logic [31:0] rnd;
    target = acc_cnt + n;
    cycles = 0;
    while (acc_cnt < target && cycles < n * 40) begin
      if (rand_stall) begin
        rnd     = $random(seed);
        stall_i = rnd[0];
      end
      step();
      cycles++;
    end
    stall_i = 1'b0;
    if (acc_cnt < target) begin
      $display("timeout in %s: %0d of %0d instructions accepted after %0d cycles",
               what, n - (target - acc_cnt), n, cycles);
      err_cnt++;
    end
  endtask

  task automatic wait_valid(input string what);
    int cycles;
    cycles = 0;
    while (!inst_valid_o && cycles < 40) begin
      step();
      cycles++;
    end
    if (!inst_valid_o) begin
      $display("timeout in %s: no valid instruction after %0d cycles", what, cycles);
      err_cnt++;
    end
  endtask

  // read still in flight when arvalid is up
  task automatic wait_arvalid(input string what);
    int cycles;
    cycles = 0;
    while (!fetch_top_i.arvalid && cycles < 40) begin
      step();
      cycles++;
    end
    if (!fetch_top_i.arvalid) begin
      $display("timeout in %s: no read request after %0d cycles", what, cycles);
      err_cnt++;
    end
  endtask

  task automatic report(input string name, input int err_start);
    tests_run++;
    if (err_cnt == err_start) begin
      $display("%s: PASS", name);
    end else begin
      tests_failed++;
      $display("%s: FAIL (%0d errors)", name, err_cnt - err_start);
    end
  endtask

  initial begin
    int e0;
    int f0;
    seed          = 70;
    rst_n         = 1'b0;
    stall_i       = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    $readmemh("test/prog.hex", prog);
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // reset values, then first fetch from RESET_PC
    e0 = err_cnt;
    check_value("inst_valid_o", 64'd0, 64'(inst_valid_o));
    check_value("inst_fault_o", 64'd0, 64'(inst_fault_o));
    check_value("inst_o", 64'(NOP_WORD), 64'(inst_o));
    wait_accepts(1, 1'b0, "reset");
    report("reset", e0);

    // rest of the first half, both halves of each beat
    e0 = err_cnt;
    wait_accepts(7, 1'b0, "sequential");
    report("sequential", e0);

    e0 = err_cnt;
    wait_accepts(6, 1'b1, "random stall");
    report("random stall", e0);

    // kill a read in flight, then flush a stalled slot
    e0 = err_cnt;
    wait_arvalid("redirect");
    pulse_redirect(RESET_PC + 64'h10);
    wait_accepts(4, 1'b0, "redirect");
    stall_i = 1'b1;
    wait_valid("redirect under stall");
    pulse_redirect(RESET_PC + 64'h24);
    stall_i = 1'b0;
    wait_accepts(3, 1'b0, "redirect under stall");
    report("redirect", e0);

    // past the end gives faults, then back in range
    e0 = err_cnt;
    f0 = fault_cnt;
    pulse_redirect(RESET_PC + 64'(MEM_WORDS * 4));
    wait_accepts(2, 1'b0, "fault");
    check_value("fault count", 64'd2, 64'(fault_cnt - f0));
    pulse_redirect(RESET_PC + 64'h8);
    wait_accepts(3, 1'b0, "fault recovery");
    check_value("fault count", 64'd2, 64'(fault_cnt - f0));
    report("fault", e0);

    $display("tests run %0d, failed %0d, errors %0d, instructions accepted %0d",
             tests_run, tests_failed, err_cnt, acc_cnt);
    if (err_cnt == 0 && tests_failed == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- test/prog.hex
// one 32-bit instruction word per line, hex
// line n holds the word at RESET_PC + 4*n
00500093
00a00113
002081b3
40208233
0020f2b3
0020e333
0020c3b3
00209433
0020b4b3
00312023
00012503
00150513
fe0508e3
00b50633
00c00693
0000006f

//--- compile.f
verilog/fetch_pkg.sv
verilog/pc_gen.sv
verilog/axil_read_master.sv
verilog/axil_imem.sv
verilog/if_stage.sv
verilog/fetch_top.sv
test/fetch_chk.sv
test/fetch_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := fetch_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
